// File: usbLinePkg.sv
package usbLinePkg;

    // Full speed bit timing from the 48 MHz clock
    localparam int unsigned ClksPerBit = 4;

    // Line states as {D+, D-}
    localparam logic [1:0] LineJ   = 2'b10;
    localparam logic [1:0] LineK   = 2'b01;
    localparam logic [1:0] LineSe0 = 2'b00;

    // KJKJKJKK after NRZI decode, first bit in bit 0
    localparam logic [7:0] SyncPattern = 8'h80;

    localparam int unsigned StuffLimit = 6; // Ones before a forced zero

    // Bit times of silence before a turnaround timeout
    localparam int unsigned TimeoutBits = 18;

endpackage

// File: usbPacketPkg.sv
package usbPacketPkg;

    // PID nibbles, lower half of the PID byte
    localparam logic [3:0] PidOut   = 4'b0001;
    localparam logic [3:0] PidIn    = 4'b1001;
    localparam logic [3:0] PidSetup = 4'b1101;
    localparam logic [3:0] PidData0 = 4'b0011;
    localparam logic [3:0] PidData1 = 4'b1011;
    localparam logic [3:0] PidAck   = 4'b0010;

    // Generator polynomials without the leading term
    localparam logic [4:0]  Crc5Poly  = 5'b00101;
    localparam logic [15:0] Crc16Poly = 16'h8005;

    // Register contents after a packet with its own CRC shifted in
    localparam logic [4:0]  Crc5Residue  = 5'b01100;
    localparam logic [15:0] Crc16Residue = 16'h800D;

    // Receive FSM phases
    localparam logic [2:0] RxIdle = 3'd0;
    localparam logic [2:0] RxSync = 3'd1;
    localparam logic [2:0] RxPid  = 3'd2;
    localparam logic [2:0] RxData = 3'd3;
    localparam logic [2:0] RxDone = 3'd4;

    // PID byte, assembled raw and read back as PID plus check
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] check; // Complement of pid
            logic [3:0] pid;
        } field;
    } pidByteT;

endpackage

// File: usbSerialFrontend.sv
`timescale 1ns/1ps

module usbSerialFrontend import usbLinePkg::*; (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic pinP_i,
    input  logic pinN_i,
    output logic dataInP_o,
    output logic dpEdge_o,
    output logic isValidDPSignal_o,
    output logic eopDetected_o,
    input  logic ackEOP_i
);

    logic [1:0] pSync;
    logic [1:0] nSync;
    logic       dpPrev;
    logic [1:0] lineState;
    logic [1:0] se0Cnt; // Consecutive SE0 samples, saturating
    logic       isSe0;

    assign lineState = {pSync[1], nSync[1]};
    assign isSe0     = lineState == LineSe0;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            pSync         <= 2'b11; // Start out in idle J
            nSync         <= 2'b00;
            dpPrev        <= 1'b1;
            se0Cnt        <= '0;
            eopDetected_o <= 1'b0;
        end else begin
            pSync  <= {pSync[0], pinP_i};
            nSync  <= {nSync[0], pinN_i};
            dpPrev <= pSync[1];

            if (!isSe0) begin
                se0Cnt <= '0;
            end else if (se0Cnt != 2'd3) begin
                se0Cnt <= se0Cnt + 2'd1;
            end

            if (isSe0 && se0Cnt == 2'd1) begin
                eopDetected_o <= 1'b1; // Second SE0 sample in a row
            end else if (ackEOP_i) begin
                eopDetected_o <= 1'b0;
            end
        end
    end

    assign dataInP_o         = pSync[1];
    assign dpEdge_o          = pSync[1] ^ dpPrev;
    assign isValidDPSignal_o = (lineState == LineJ) || (lineState == LineK);

endmodule

// File: usbDpll.sv
`timescale 1ns/1ps

module usbDpll import usbLinePkg::*; (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic dpEdge_i,
    output logic bitStrobe_o,
    output logic gotSignal_o
);

    logic [$clog2(ClksPerBit)-1:0] phase;
    logic [$clog2(ClksPerBit)-1:0] phaseNext;

    // Phase within the current bit, cycle of the edge counts as zero
    always_comb begin
        if (phase == ClksPerBit - 1) begin
            phaseNext = '0;
        end else begin
            phaseNext = phase + 1'b1;
        end
    end

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            phase       <= '0;
            bitStrobe_o <= 1'b0;
            gotSignal_o <= 1'b0;
        end else if (dpEdge_i) begin
            // Realign so the strobe lands two cycles after the edge
            phase       <= 1;
            bitStrobe_o <= 1'b0;
            gotSignal_o <= 1'b1;
        end else begin
            phase       <= phaseNext;
            bitStrobe_o <= gotSignal_o && (phaseNext == ClksPerBit / 2); // Mid-bit
        end
    end

endmodule

// File: usbBitDestuffer.sv
`timescale 1ns/1ps

module usbBitDestuffer import usbLinePkg::*; (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic stuffRst_i,
    input  logic stuffBit_i,
    input  logic stuffBitValid_i,
    output logic stuffedBit_o,
    output logic stuffError_o
);

    logic [$clog2(StuffLimit+1)-1:0] onesCnt;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i || stuffRst_i) begin
            onesCnt      <= '0;
            stuffError_o <= 1'b0;
        end else if (stuffBitValid_i) begin
            if (onesCnt == StuffLimit) begin
                onesCnt <= '0;
                if (stuffBit_i) begin
                    stuffError_o <= 1'b1; // Seventh one in a row
                end
            end else if (stuffBit_i) begin
                onesCnt <= onesCnt + 1'b1;
            end else begin
                onesCnt <= '0;
            end
        end
    end

    // Known ahead of the bit itself
    assign stuffedBit_o = onesCnt == StuffLimit;

endmodule

// File: usbCrc.sv
`timescale 1ns/1ps

module usbCrc import usbPacketPkg::*; (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic crcRst_i,
    input  logic useCrc16_i,
    input  logic crcBit_i,
    input  logic crcBitValid_i,
    output logic crcOk_o
);

    logic [15:0] crcReg; // CRC5 lives in the low five bits
    logic        fb16;
    logic        fb5;

    assign fb16 = crcBit_i ^ crcReg[15];
    assign fb5  = crcBit_i ^ crcReg[4];

    always_ff @(posedge clk48_i) begin
        if (!rstN_i || crcRst_i) begin
            crcReg <= '1;
        end else if (crcBitValid_i) begin
            if (useCrc16_i) begin
                crcReg <= {crcReg[14:0], 1'b0} ^ (fb16 ? Crc16Poly : 16'h0000);
            end else begin
                crcReg[4:0] <= {crcReg[3:0], 1'b0} ^ (fb5 ? Crc5Poly : 5'b00000);
            end
        end
    end

    // Data and received CRC both went through the register
    assign crcOk_o = useCrc16_i ? (crcReg == Crc16Residue)
                                : (crcReg[4:0] == Crc5Residue);

endmodule

// File: usbRxTimeout.sv
`timescale 1ns/1ps

module usbRxTimeout import usbLinePkg::*; (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic restart_i,
    input  logic bitStrobe_i,
    input  logic gotSignal_i,
    output logic gotTimeout_o
);

    logic [$clog2(ClksPerBit)-1:0]    divCnt;
    logic [$clog2(TimeoutBits+1)-1:0] bitCnt;
    logic                             bitTick;
    logic                             timeoutFlag;

    assign bitTick = divCnt == ClksPerBit - 1;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i || restart_i) begin
            divCnt      <= '0;
            bitCnt      <= '0;
            timeoutFlag <= 1'b0;
        end else begin
            // Free running bit divider, pulled into phase by the DPLL when it has one
            if (bitStrobe_i || bitTick) begin
                divCnt <= '0;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
            if (bitTick && bitCnt != TimeoutBits) begin
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == TimeoutBits - 1 && !gotSignal_i) begin
                    timeoutFlag <= 1'b1;
                end
            end
        end
    end

    assign gotTimeout_o = timeoutFlag && !restart_i;

endmodule

// File: usbRx.sv
`timescale 1ns/1ps

module usbRx import usbLinePkg::*, usbPacketPkg::*; (
    input  logic       clk48_i,
    input  logic       rstN_i,
    input  logic       dataInP_i,
    input  logic       isValidDPSignal_i,
    input  logic       eopDetected_i,
    input  logic       bitStrobe_i,
    input  logic       stuffedBit_i,
    input  logic       stuffError_i,
    input  logic       crcOk_i,
    input  logic       rxAcceptNewData_i,
    output logic       ackEOP_o,
    output logic       stuffRst_o,
    output logic       stuffBit_o,
    output logic       stuffBitValid_o,
    output logic       crcRst_o,
    output logic       useCrc16_o,
    output logic       crcBit_o,
    output logic       crcBitValid_o,
    output logic       rxDataValid_o,
    output logic [7:0] rxData_o,
    output logic       rxDone_o,
    output logic       keepPacket_o
);

    logic [2:0] state;
    logic       lastLevel; // Line level at the previous bit
    logic       decoded;
    logic       bitEvt;
    logic       inPacket;
    logic       unstuffedEvt;
    logic [7:0] shiftReg;
    logic [7:0] newByte;
    logic [2:0] bitCnt;
    logic       byteDone;
    logic [7:0] pendingByte; // Newest byte, held back until we know if it is the last
    logic       havePending;
    logic       pidBad;
    logic       needCrc;
    logic       overflow;
    logic       keepVerdict;
    logic       outFree;
    logic       pushByte;
    logic       storePending;
    logic       moveOut;
    logic       finish;
    pidByteT    pidView;
    logic       pidKnown;
    logic       pidIsData;
    logic       pidIsHandshake;

    assign decoded      = ~(dataInP_i ^ lastLevel); // NRZI, no transition is a one
    assign bitEvt       = bitStrobe_i && isValidDPSignal_i;
    assign inPacket     = (state == RxPid) || (state == RxData);
    assign unstuffedEvt = bitEvt && inPacket && !stuffedBit_i;
    assign newByte      = {decoded, shiftReg[7:1]}; // LSB first
    assign byteDone     = unstuffedEvt && bitCnt == 3'd7;
    assign outFree      = !rxDataValid_o || rxAcceptNewData_i;
    assign pushByte     = byteDone && !overflow;
    assign storePending = pushByte && (!havePending || outFree);
    assign finish       = (state == RxDone) && outFree;
    assign moveOut      = (pushByte && havePending && outFree) || finish;

    always_comb begin
        pidView.raw    = newByte;
        pidKnown       = 1'b0;
        pidIsData      = 1'b0;
        pidIsHandshake = 1'b0;
        case (pidView.field.pid)
            PidOut, PidIn, PidSetup: pidKnown = 1'b1;
            PidData0, PidData1: begin
                pidKnown  = 1'b1;
                pidIsData = 1'b1;
            end
            PidAck: begin
                pidKnown       = 1'b1;
                pidIsHandshake = 1'b1;
            end
            default: pidKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            state         <= RxIdle;
            lastLevel     <= 1'b1;
            bitCnt        <= '0;
            havePending   <= 1'b0;
            pidBad        <= 1'b0;
            needCrc       <= 1'b0;
            useCrc16_o    <= 1'b0;
            overflow      <= 1'b0;
            keepVerdict   <= 1'b0;
            rxDataValid_o <= 1'b0;
            rxDone_o      <= 1'b0;
            keepPacket_o  <= 1'b0;
        end else begin
            if (bitEvt) begin
                lastLevel <= dataInP_i;
            end
            if (rxDataValid_o && rxAcceptNewData_i) begin
                rxDataValid_o <= 1'b0;
                rxDone_o      <= 1'b0;
            end
            if (moveOut) begin
                rxDataValid_o <= 1'b1;
                rxDone_o      <= finish;
            end
            if (storePending) begin
                havePending <= 1'b1;
            end
            if (pushByte && havePending && !outFree) begin
                overflow <= 1'b1; // Old byte still waiting, the rest is dropped
            end

            case (state)
                RxIdle: begin
                    if (!eopDetected_i && bitEvt && !decoded) begin
                        state <= RxSync; // First K after idle
                    end
                end
                RxSync: begin
                    if (eopDetected_i) begin
                        state <= RxIdle;
                    end else if (bitEvt && decoded) begin
                        if (newByte == SyncPattern) begin
                            state        <= RxPid;
                            bitCnt       <= '0;
                            pidBad       <= 1'b0;
                            overflow     <= 1'b0;
                            keepPacket_o <= 1'b0; // New packet starts
                        end else begin
                            state <= RxIdle;
                        end
                    end
                end
                RxPid, RxData: begin
                    if (eopDetected_i) begin
                        keepVerdict <= !pidBad && !overflow && !stuffError_i &&
                                       bitCnt == 3'd0 && (crcOk_i || !needCrc);
                        state <= (state == RxData) ? RxDone : RxIdle;
                    end else if (unstuffedEvt) begin
                        bitCnt <= bitCnt + 3'd1;
                        if (byteDone && state == RxPid) begin
                            pidBad     <= !pidKnown ||
                                          (pidView.field.check != ~pidView.field.pid);
                            needCrc    <= !pidIsHandshake;
                            useCrc16_o <= pidIsData;
                            state      <= RxData;
                        end
                    end
                end
                RxDone: begin
                    if (outFree) begin
                        keepPacket_o <= keepVerdict; // Goes out with the last byte
                        havePending  <= 1'b0;
                        state        <= RxIdle;
                    end
                end
                default: state <= RxIdle;
            endcase
        end
    end

    always_ff @(posedge clk48_i) begin
        if (bitEvt && state == RxIdle) begin
            shiftReg <= {decoded, 7'h7F}; // Ones ahead so SYNC needs all its zeros
        end else if ((bitEvt && state == RxSync) || unstuffedEvt) begin
            shiftReg <= newByte;
        end
        if (moveOut) begin
            rxData_o <= pendingByte;
        end
        if (storePending) begin
            pendingByte <= newByte;
        end
    end

    assign ackEOP_o        = eopDetected_i && state != RxDone;
    assign stuffRst_o      = !inPacket;
    assign stuffBit_o      = decoded;
    assign stuffBitValid_o = bitEvt && inPacket; // Stuff bits too, so the count restarts
    assign crcRst_o        = state != RxData;
    assign crcBit_o        = decoded;
    assign crcBitValid_o   = unstuffedEvt && state == RxData;

endmodule

// File: usbRxConnection.sv
`timescale 1ns/1ps

module usbRxConnection (
    input  logic       clk48_i,
    input  logic       rstN_i,
    input  logic       usbDp_i,
    input  logic       usbDn_i,
    input  logic       rxAcceptNewData_i, // Backend ready for the next byte
    input  logic       resetTimeout_i,
    output logic       rxDone_o,          // Current byte is the last of the packet
    output logic       rxDataValid_o,
    output logic [7:0] rxData_o,
    output logic       keepPacket_o,      // Verdict, valid together with rxDone_o
    output logic       gotTimeout_o
);

    logic dataInP;
    logic dpEdge;
    logic isValidDPSignal;
    logic eopDetected;
    logic ackEOP;
    logic bitStrobe;
    logic gotSignal;
    logic stuffRst;
    logic stuffBit;
    logic stuffBitValid;
    logic stuffedBit;
    logic stuffError;
    logic crcRst;
    logic useCrc16;
    logic crcBit;
    logic crcBitValid;
    logic crcOk;

    usbSerialFrontend serialFrontend (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .pinP_i(usbDp_i),
        .pinN_i(usbDn_i),
        .dataInP_o(dataInP),
        .dpEdge_o(dpEdge),
        .isValidDPSignal_o(isValidDPSignal),
        .eopDetected_o(eopDetected),
        .ackEOP_i(ackEOP)
    );

    usbDpll rxDpll (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .dpEdge_i(dpEdge),
        .bitStrobe_o(bitStrobe),
        .gotSignal_o(gotSignal)
    );

    usbRxTimeout rxTimeout (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .restart_i(resetTimeout_i),
        .bitStrobe_i(bitStrobe),
        .gotSignal_i(gotSignal),
        .gotTimeout_o(gotTimeout_o)
    );

    usbCrc crcEngine (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .crcRst_i(crcRst),
        .useCrc16_i(useCrc16),
        .crcBit_i(crcBit),
        .crcBitValid_i(crcBitValid),
        .crcOk_o(crcOk)
    );

    usbBitDestuffer bitDestuffer (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .stuffRst_i(stuffRst),
        .stuffBit_i(stuffBit),
        .stuffBitValid_i(stuffBitValid),
        .stuffedBit_o(stuffedBit),
        .stuffError_o(stuffError)
    );

    usbRx rxCtrl (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .dataInP_i(dataInP),
        .isValidDPSignal_i(isValidDPSignal),
        .eopDetected_i(eopDetected),
        .bitStrobe_i(bitStrobe),
        .stuffedBit_i(stuffedBit),
        .stuffError_i(stuffError),
        .crcOk_i(crcOk),
        .rxAcceptNewData_i(rxAcceptNewData_i),
        .ackEOP_o(ackEOP),
        .stuffRst_o(stuffRst),
        .stuffBit_o(stuffBit),
        .stuffBitValid_o(stuffBitValid),
        .crcRst_o(crcRst),
        .useCrc16_o(useCrc16),
        .crcBit_o(crcBit),
        .crcBitValid_o(crcBitValid),
        .rxDataValid_o(rxDataValid_o),
        .rxData_o(rxData_o),
        .rxDone_o(rxDone_o),
        .keepPacket_o(keepPacket_o)
    );

endmodule

// File: usbRxChk.sv
`timescale 1ns/1ps

module usbRxChk (
    input logic       clk48_i,
    input logic       rstN_i,
    input logic       rxAcceptNewData_i,
    input logic       resetTimeout_i,
    input logic       rxDataValid_o,
    input logic [7:0] rxData_o,
    input logic       rxDone_o,
    input logic       keepPacket_o,
    input logic       gotTimeout_o
);

    int assertFails = 0; // Failed assertions so far

    // Waiting byte must not move while the backend stalls
    stallHold: assert property (@(posedge clk48_i) disable iff (!rstN_i)
        rxDataValid_o && !rxAcceptNewData_i |=>
            rxDataValid_o && $stable(rxData_o) && $stable(rxDone_o))
        else begin
            assertFails++;
            $error("rxData_o or rxDone_o changed while the byte was stalled");
        end

    doneWithValid: assert property (@(posedge clk48_i) disable iff (!rstN_i)
        rxDone_o |-> rxDataValid_o)
        else begin
            assertFails++;
            $error("rxDone_o high without rxDataValid_o");
        end

    quietInReset: assert property (@(posedge clk48_i)
        !rstN_i |=> !rxDataValid_o && !rxDone_o && !keepPacket_o && !gotTimeout_o)
        else begin
            assertFails++;
            $error("Output active during reset");
        end

    // Restart clears the timeout flag itself and not only the output
    timeoutCleared: assert property (@(posedge clk48_i) disable iff (!rstN_i)
        resetTimeout_i |=> !gotTimeout_o)
        else begin
            assertFails++;
            $error("gotTimeout_o high in the cycle after resetTimeout_i");
        end

endmodule

bind usbRxConnection usbRxChk rxChk (
    .clk48_i(clk48_i),
    .rstN_i(rstN_i),
    .rxAcceptNewData_i(rxAcceptNewData_i),
    .resetTimeout_i(resetTimeout_i),
    .rxDataValid_o(rxDataValid_o),
    .rxData_o(rxData_o),
    .rxDone_o(rxDone_o),
    .keepPacket_o(keepPacket_o),
    .gotTimeout_o(gotTimeout_o)
);

// File: tbUsbRxConnection.sv
`timescale 1ns/1ps

module tbUsbRxConnection import usbLinePkg::*, usbPacketPkg::*; ();

    localparam int unsigned ClkPeriod     = 40;
    localparam int unsigned NumPackets    = 8;
    localparam int unsigned MaxPacketBits = 140; // SYNC, stuffed bytes, EOP and idle gap
    localparam int unsigned WatchdogCycles =
        NumPackets * MaxPacketBits * ClksPerBit + 2000;

    logic       clk48_i;
    logic       rstN_i;
    logic       usbDp;
    logic       usbDn;
    logic       rxAccept;
    logic       resetTimeout;
    logic       rxDone;
    logic       rxDataValid;
    logic [7:0] rxData;
    logic       keepPacket;
    logic       gotTimeout;

    integer     seed;
    int         mismatchCnt;
    int         failCnt;
    int         totalFails;
    int         waitCnt;
    logic       pktBits[$]; // Unstuffed bits after SYNC in line order
    logic [7:0] expQ[$];
    logic [7:0] rxQ[$];
    logic       packetDone;
    logic       lastKeep;
    logic       sawTimeout;

    usbRxConnection usbRxConnection_i (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .usbDp_i(usbDp),
        .usbDn_i(usbDn),
        .rxAcceptNewData_i(rxAccept),
        .resetTimeout_i(resetTimeout),
        .rxDone_o(rxDone),
        .rxDataValid_o(rxDataValid),
        .rxData_o(rxData),
        .keepPacket_o(keepPacket),
        .gotTimeout_o(gotTimeout)
    );

    initial begin
        clk48_i = 1'b0;
        forever #(ClkPeriod / 2) clk48_i = ~clk48_i;
    end

    // Backend model that sees each transfer half a cycle before its edge
    always @(negedge clk48_i) begin
        if (rxDataValid && rxAccept) begin
            rxQ.push_back(rxData);
            if (rxDone) begin
                lastKeep   = keepPacket;
                packetDone = 1'b1;
            end
        end
        if (gotTimeout) sawTimeout = 1'b1;
    end

    task automatic driveState(input logic p, input logic n, input int cycles);
        repeat (cycles) begin
            @(posedge clk48_i);
            #2;
            usbDp = p;
            usbDn = n;
        end
    endtask

    task automatic addBits(input logic [15:0] value, input int n);
        for (int i = 0; i < n; i++) pktBits.push_back(value[i]); // LSB first
    endtask

    // CRC over everything after the PID
    task automatic addCrc5();
        logic [4:0] crc;
        logic       fb;
        crc = '1;
        for (int i = 8; i < pktBits.size(); i++) begin
            fb  = pktBits[i] ^ crc[4];
            crc = {crc[3:0], 1'b0} ^ (fb ? Crc5Poly : 5'b00000);
        end
        for (int i = 4; i >= 0; i--) pktBits.push_back(~crc[i]); // Sent inverted and MSB first
    endtask

    task automatic addCrc16();
        logic [15:0] crc;
        logic        fb;
        crc = '1;
        for (int i = 8; i < pktBits.size(); i++) begin
            fb  = pktBits[i] ^ crc[15];
            crc = {crc[14:0], 1'b0} ^ (fb ? Crc16Poly : 16'h0000);
        end
        for (int i = 15; i >= 0; i--) pktBits.push_back(~crc[i]);
    endtask

    // NRZI with bit stuffing where dropStuff leaves out the first stuff bit
    task automatic transmit(input bit dropStuff);
        logic level;
        int   ones;
        bit   dropped;
        level   = 1'b1;
        ones    = 0;
        dropped = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (!SyncPattern[i]) level = ~level;
            driveState(level, ~level, ClksPerBit);
        end
        foreach (pktBits[i]) begin
            if (!pktBits[i]) level = ~level; // Zero is a transition
            driveState(level, ~level, ClksPerBit);
            ones = pktBits[i] ? ones + 1 : 0;
            if (ones == StuffLimit) begin
                ones = 0;
                if (dropStuff && !dropped) begin
                    dropped = 1'b1;
                end else begin
                    level = ~level;
                    driveState(level, ~level, ClksPerBit);
                end
            end
        end
        driveState(1'b0, 1'b0, 2 * ClksPerBit); // SE0 SE0 J
        driveState(1'b1, 1'b0, ClksPerBit);
        driveState(1'b1, 1'b0, 20 * ClksPerBit);
    endtask

    // Holds ready low from the start until len cycles after the first valid byte
    task automatic applyStall(input int len);
        if (len > 0) begin
            @(posedge clk48_i);
            #2;
            rxAccept = 1'b0;
            while (!rxDataValid) @(negedge clk48_i);
            repeat (len) @(posedge clk48_i);
            #2;
            rxAccept = 1'b1;
        end
    endtask

    task automatic runPacket(input bit dropStuff, input int stallCycles,
                             input bit expectKeep, input bit checkBytes, input string name);
        logic [7:0] b;
        int         cnt;
        expQ.delete();
        for (int i = 0; i + 8 <= pktBits.size(); i += 8) begin
            for (int j = 0; j < 8; j++) b[j] = pktBits[i + j];
            expQ.push_back(b);
        end
        rxQ.delete();
        packetDone = 1'b0;
        fork
            transmit(dropStuff);
            applyStall(stallCycles);
        join
        cnt = 0;
        while (!packetDone && cnt < 200) begin
            @(negedge clk48_i);
            cnt++;
        end
        assert (packetDone) else begin
            failCnt++;
            $display("%s: no last byte with rxDone_o arrived", name);
        end
        if (packetDone) begin
            assert (lastKeep == expectKeep) else begin
                mismatchCnt++;
                $display("Mismatch at %0t: %s keepPacket_o %0b, expected %0b",
                         $time, name, lastKeep, expectKeep);
            end
            if (checkBytes) begin
                assert (rxQ.size() == expQ.size()) else begin
                    mismatchCnt++;
                    $display("Mismatch at %0t: %s got %0d bytes, expected %0d",
                             $time, name, rxQ.size(), expQ.size());
                end
                foreach (expQ[i]) begin
                    if (i < rxQ.size()) begin
                        assert (rxQ[i] == expQ[i]) else begin
                            mismatchCnt++;
                            $display("Mismatch at %0t: %s byte %0d is %h, expected %h",
                                     $time, name, i, rxQ[i], expQ[i]);
                        end
                    end
                end
            end
        end
    endtask

    initial begin
        repeat (WatchdogCycles) @(posedge clk48_i);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h7bed;
        usbDp        = 1'b1; // Idle J
        usbDn        = 1'b0;
        rxAccept     = 1'b1;
        resetTimeout = 1'b1;
        rstN_i       = 1'b0;
        mismatchCnt  = 0;
        failCnt      = 0;
        packetDone   = 1'b0;
        lastKeep     = 1'b0;
        sawTimeout   = 1'b0;
        repeat (10) @(posedge clk48_i);
        #2;
        rstN_i = 1'b1;
        repeat (5) @(posedge clk48_i);

        // Idle line after restart runs before the first edge latches gotSignal
        #2;
        resetTimeout = 1'b0;
        waitCnt = 0;
        while (!gotTimeout && waitCnt < 200) begin
            @(posedge clk48_i); // Edges that see the restart low
            waitCnt++;
            @(negedge clk48_i);
        end
        assert (gotTimeout && waitCnt == TimeoutBits * ClksPerBit) else begin
            mismatchCnt++;
            $display("Mismatch at %0t: gotTimeout_o after %0d cycles, expected %0d",
                     $time, waitCnt, TimeoutBits * ClksPerBit);
        end
        @(posedge clk48_i);
        #2;
        resetTimeout = 1'b1;
        repeat (4) @(posedge clk48_i);
        #2;
        resetTimeout = 1'b0;
        sawTimeout   = 1'b0;
        repeat (10) @(posedge clk48_i);

        pktBits.delete();
        addBits({~PidOut, PidOut}, 8);
        addBits(16'h0135, 11); // Address and endpoint
        addCrc5();
        runPacket(1'b0, 0, 1'b1, 1'b1, "OUT token");
        repeat (TimeoutBits * ClksPerBit) @(posedge clk48_i);
        assert (!sawTimeout) else begin
            failCnt++;
            $display("gotTimeout_o rose although a packet arrived in time");
        end

        pktBits[pktBits.size() - 2] = ~pktBits[pktBits.size() - 2];
        runPacket(1'b0, 0, 1'b0, 1'b1, "OUT token, bad CRC5");

        pktBits.delete();
        addBits({~PidData0, PidData0}, 8);
        repeat (8) addBits($random(seed), 8);
        addCrc16();
        runPacket(1'b0, 0, 1'b1, 1'b1, "DATA0 random");

        pktBits.delete();
        addBits({~PidData1, PidData1}, 8);
        repeat (4) addBits(16'h00FF, 8);
        addCrc16();
        runPacket(1'b0, 0, 1'b1, 1'b1, "DATA1 stuffed");
        runPacket(1'b1, 0, 1'b0, 1'b0, "DATA1 missing stuff bit");

        pktBits.delete();
        addBits(16'h0013, 8); // Check nibble is not the complement
        repeat (2) addBits($random(seed), 8);
        addCrc16();
        runPacket(1'b0, 0, 1'b0, 1'b1, "bad PID check");

        pktBits.delete();
        addBits({~PidData0, PidData0}, 8);
        repeat (4) addBits($random(seed), 8);
        addCrc16();
        runPacket(1'b0, 20, 1'b1, 1'b1, "short stall");

        pktBits.delete();
        addBits({~PidData0, PidData0}, 8);
        repeat (6) addBits($random(seed), 8);
        addCrc16();
        runPacket(1'b0, 200, 1'b0, 1'b0, "long stall");

        totalFails = failCnt + usbRxConnection_i.rxChk.assertFails;
        $display("Errors: %0d mismatches, %0d other failures", mismatchCnt, totalFails);
        if (mismatchCnt == 0 && totalFails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
usbLinePkg.sv
usbPacketPkg.sv
usbSerialFrontend.sv
usbDpll.sv
usbBitDestuffer.sv
usbCrc.sv
usbRxTimeout.sv
usbRx.sv
usbRxConnection.sv
usbRxChk.sv
tbUsbRxConnection.sv

// File: Makefile
SIM   ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP   ?= tbUsbRxConnection
FLIST ?= flist.f
LOG   ?= sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
